/* design/sdram_dev_pkg.sv */
package sdram_dev_pkg;

    // cs, ras, cas, we
    typedef enum logic [3:0] {
        CMD_NOP       = 4'b0111,
        CMD_ACTIVE    = 4'b0011,
        CMD_READ      = 4'b0101,
        CMD_WRITE     = 4'b0100,
        CMD_PRECHARGE = 4'b0010,
        CMD_REFRESH   = 4'b0001
    } sdram_cmd_t;

    localparam int BANK_W    = 2;
    localparam int ROW_W     = 13;
    localparam int COL_W     = 8;
    localparam int DATA_W    = 32;
    localparam int NUM_BANKS = 4;

    // delay counter loads, wait lasts load + 1 cycles
    localparam int DLY_W = 3;
    localparam logic [DLY_W-1:0] T_ACT = 3'd2;
    localparam logic [DLY_W-1:0] T_PRE = 3'd2;
    localparam logic [DLY_W-1:0] T_REF = 3'd6;

    localparam int CAS_LATENCY      = 3;
    localparam int REF_CNT_W        = 10;
    localparam int REFRESH_INTERVAL = 750;
    localparam int A10_ALL          = 10;   // a[10] high means all banks

endpackage

/* design/sdram_user_pkg.sv */
package sdram_user_pkg;

    localparam int USER_ADDR_W = 23;

    // row = {addr[22:13], addr[10:8]}
    localparam int ROW_HI_MSB = 22;
    localparam int ROW_HI_LSB = 13;
    localparam int ROW_LO_MSB = 10;
    localparam int ROW_LO_LSB = 8;

    // bank sits between the two row parts
    localparam int BANK_MSB = 12;
    localparam int BANK_LSB = 11;

    localparam int COL_MSB = 7;
    localparam int COL_LSB = 0;

endpackage

/* design/refresh_timer.sv */
`timescale 1ns/1ps

module refresh_timer (
    input  logic clk,
    input  logic rst,
    input  logic i_refresh_ack,
    output logic o_refresh_req
);
    import sdram_dev_pkg::*;

    logic [REF_CNT_W-1:0] ref_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            ref_cnt       <= '0;
            o_refresh_req <= 1'b0;
        end else begin
            if (ref_cnt > REFRESH_INTERVAL) begin
                ref_cnt       <= '0;
                o_refresh_req <= 1'b1;     // sticky until acknowledged
            end else begin
                ref_cnt <= ref_cnt + 1'b1;
                if (i_refresh_ack)
                    o_refresh_req <= 1'b0;
            end
        end
    end

endmodule

/* design/open_row_table.sv */
`timescale 1ns/1ps

module open_row_table (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [sdram_dev_pkg::BANK_W-1:0] i_bank,
    input  logic [sdram_dev_pkg::ROW_W-1:0]  i_row,
    input  logic                             i_activate,
    input  logic                             i_precharge_all,
    output logic                             o_bank_open,
    output logic                             o_row_hit
);
    import sdram_dev_pkg::*;

    logic [NUM_BANKS-1:0] open_q;
    logic [ROW_W-1:0]     row_q [NUM_BANKS];

    // one open flag per bank
    always_ff @(posedge clk) begin
        if (rst) begin
            open_q <= '0;
        end else if (i_precharge_all) begin
            open_q <= '0;
        end else if (i_activate) begin
            open_q[i_bank] <= 1'b1;
        end
    end

    // row held per bank, only meaningful while the flag is set
    always_ff @(posedge clk) begin
        if (i_activate)
            row_q[i_bank] <= i_row;
    end

    assign o_bank_open = open_q[i_bank];
    assign o_row_hit   = open_q[i_bank] && (row_q[i_bank] == i_row);

endmodule

/* design/read_capture.sv */
`timescale 1ns/1ps

module read_capture (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             i_read_issued,
    input  logic [sdram_dev_pkg::DATA_W-1:0] i_sdram_dqi,
    output logic [sdram_dev_pkg::DATA_W-1:0] o_data_out,
    output logic                             o_out_valid
);
    import sdram_dev_pkg::*;

    // CAS_LATENCY + 1 stages, strobe enters the cycle before READ hits the pins
    logic [CAS_LATENCY:0] strobe_sr;

    always_ff @(posedge clk) begin
        if (rst) begin
            strobe_sr   <= '0;
            o_out_valid <= 1'b0;
        end else begin
            strobe_sr   <= {strobe_sr[CAS_LATENCY-1:0], i_read_issued};
            o_out_valid <= strobe_sr[CAS_LATENCY];
        end
    end

    // data is on the pins when the strobe falls out of the line
    always_ff @(posedge clk) begin
        if (strobe_sr[CAS_LATENCY])
            o_data_out <= i_sdram_dqi;
    end

endmodule

/* design/sdram_cmd_seq.sv */
`timescale 1ns/1ps

module sdram_cmd_seq (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   i_in_valid,
    input  logic                                   i_rw,
    input  logic [sdram_user_pkg::USER_ADDR_W-1:0] i_user_addr,
    input  logic [sdram_dev_pkg::DATA_W-1:0]       i_data_in,
    output logic                                   o_busy,
    input  logic                                   i_refresh_req,
    output logic                                   o_refresh_ack,
    input  logic                                   i_bank_open,
    input  logic                                   i_row_hit,
    output logic [sdram_dev_pkg::BANK_W-1:0]       o_req_bank,
    output logic [sdram_dev_pkg::ROW_W-1:0]        o_req_row,
    output logic                                   o_activate,
    output logic                                   o_precharge_all,
    output logic                                   o_read_issued,
    output logic                                   o_sdram_cle,
    output sdram_dev_pkg::sdram_cmd_t              o_sdram_cmd,
    output logic [sdram_dev_pkg::BANK_W-1:0]       o_sdram_ba,
    output logic [sdram_dev_pkg::ROW_W-1:0]        o_sdram_a,
    output logic [sdram_dev_pkg::DATA_W-1:0]       o_sdram_dqo,
    output logic                                   o_sdram_dq_oe
);
    import sdram_dev_pkg::*;
    import sdram_user_pkg::*;

    typedef enum logic [2:0] {
        ST_INIT,
        ST_IDLE,
        ST_PRECHARGE,
        ST_ACTIVATE,
        ST_READ,
        ST_WRITE,
        ST_REFRESH,
        ST_WAIT
    } state_t;

    state_t            state_q, state_d;
    state_t            next_q, next_d;     // where to go after the wait
    logic [DLY_W-1:0]  dly_q, dly_d;
    logic              req_pend_q, req_pend_d;
    logic              busy_q, busy_d;
    logic              accept;

    // latched request, already remapped
    logic              req_rw_q;
    logic [BANK_W-1:0] req_bank_q;
    logic [ROW_W-1:0]  req_row_q;
    logic [COL_W-1:0]  req_col_q;
    logic [DATA_W-1:0] req_data_q;

    // next values of the pin registers
    logic              cle_d;
    sdram_cmd_t        cmd_d;
    logic [BANK_W-1:0] ba_d;
    logic [ROW_W-1:0]  a_d;
    logic [DATA_W-1:0] dqo_d;
    logic              dq_oe_d;

    always_comb begin
        state_d    = state_q;
        next_d     = next_q;
        dly_d      = dly_q;
        req_pend_d = req_pend_q;
        accept     = 1'b0;
        cle_d      = o_sdram_cle;
        cmd_d      = CMD_NOP;
        ba_d       = '0;
        a_d        = '0;
        dqo_d      = o_sdram_dqo;
        dq_oe_d    = 1'b0;

        case (state_q)
            ST_INIT: begin
                cle_d   = 1'b1;    // only the clock enable is kept from power-up
                state_d = ST_IDLE;
            end
            ST_IDLE: begin
                if (req_pend_q) begin
                    // table now reflects the latched bank and row
                    req_pend_d = 1'b0;
                    if (i_row_hit) begin
                        state_d = req_rw_q ? ST_WRITE : ST_READ;
                    end else if (!i_bank_open) begin
                        state_d = ST_ACTIVATE;
                    end else begin
                        state_d = ST_PRECHARGE;   // row miss
                        next_d  = ST_ACTIVATE;
                    end
                end else if (i_refresh_req) begin
                    state_d = ST_PRECHARGE;
                    next_d  = ST_REFRESH;
                end else if (i_in_valid && !busy_q) begin
                    accept     = 1'b1;
                    req_pend_d = 1'b1;
                end
            end
            ST_PRECHARGE: begin
                cmd_d        = CMD_PRECHARGE;
                a_d[A10_ALL] = 1'b1;     // all banks
                dly_d        = T_PRE;
                state_d      = ST_WAIT;
            end
            ST_ACTIVATE: begin
                cmd_d   = CMD_ACTIVE;
                ba_d    = req_bank_q;
                a_d     = req_row_q;
                dly_d   = T_ACT;
                next_d  = req_rw_q ? ST_WRITE : ST_READ;
                state_d = ST_WAIT;
            end
            ST_READ: begin
                cmd_d    = CMD_READ;
                ba_d     = req_bank_q;
                a_d[9:2] = req_col_q;
                state_d  = ST_IDLE;
            end
            ST_WRITE: begin
                cmd_d    = CMD_WRITE;
                ba_d     = req_bank_q;
                a_d[9:2] = req_col_q;
                dqo_d    = req_data_q;
                dq_oe_d  = 1'b1;
                state_d  = ST_IDLE;
            end
            ST_REFRESH: begin
                cmd_d   = CMD_REFRESH;
                dly_d   = T_REF;
                next_d  = ST_IDLE;
                state_d = ST_WAIT;
            end
            ST_WAIT: begin
                dly_d = dly_q - 1'b1;
                if (dly_q == '0)
                    state_d = next_q;
            end
            default: state_d = ST_INIT;
        endcase

        // free only when settled in idle with nothing queued
        busy_d = accept || !(state_q == ST_IDLE && !req_pend_q && !i_refresh_req);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q       <= ST_INIT;
            next_q        <= ST_IDLE;
            dly_q         <= '0;
            req_pend_q    <= 1'b0;
            busy_q        <= 1'b1;
            o_sdram_cle   <= 1'b0;
            o_sdram_cmd   <= CMD_NOP;
            o_sdram_dq_oe <= 1'b0;
        end else begin
            state_q       <= state_d;
            next_q        <= next_d;
            dly_q         <= dly_d;
            req_pend_q    <= req_pend_d;
            busy_q        <= busy_d;
            o_sdram_cle   <= cle_d;
            o_sdram_cmd   <= cmd_d;
            o_sdram_dq_oe <= dq_oe_d;
        end
    end

    always_ff @(posedge clk) begin
        o_sdram_ba  <= ba_d;
        o_sdram_a   <= a_d;
        o_sdram_dqo <= dqo_d;
        if (accept) begin
            req_rw_q   <= i_rw;
            req_bank_q <= i_user_addr[BANK_MSB:BANK_LSB];
            req_row_q  <= {i_user_addr[ROW_HI_MSB:ROW_HI_LSB],
                           i_user_addr[ROW_LO_MSB:ROW_LO_LSB]};
            req_col_q  <= i_user_addr[COL_MSB:COL_LSB];
            req_data_q <= i_data_in;
        end
    end

    assign o_refresh_ack   = (state_q == ST_IDLE) && !req_pend_q && i_refresh_req;
    assign o_activate      = (state_q == ST_ACTIVATE);
    assign o_precharge_all = (state_q == ST_PRECHARGE);
    assign o_read_issued   = (state_q == ST_READ);   // READ goes onto the pins at this edge
    assign o_busy          = busy_q || i_refresh_req;
    assign o_req_bank      = req_bank_q;
    assign o_req_row       = req_row_q;

endmodule

/* design/sdram_ctrl_top.sv */
`timescale 1ns/1ps

module sdram_ctrl_top (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   i_in_valid,
    input  logic                                   i_rw,
    input  logic [sdram_user_pkg::USER_ADDR_W-1:0] i_user_addr,
    input  logic [sdram_dev_pkg::DATA_W-1:0]       i_data_in,
    output logic                                   o_busy,
    output logic [sdram_dev_pkg::DATA_W-1:0]       o_data_out,
    output logic                                   o_out_valid,
    output logic                                   o_sdram_cle,
    output logic                                   o_sdram_cs,
    output logic                                   o_sdram_ras,
    output logic                                   o_sdram_cas,
    output logic                                   o_sdram_we,
    output logic                                   o_sdram_dqm,
    output logic [sdram_dev_pkg::BANK_W-1:0]       o_sdram_ba,
    output logic [sdram_dev_pkg::ROW_W-1:0]        o_sdram_a,
    output logic [sdram_dev_pkg::DATA_W-1:0]       o_sdram_dqo,
    output logic                                   o_sdram_dq_oe,
    input  logic [sdram_dev_pkg::DATA_W-1:0]       i_sdram_dqi
);
    import sdram_dev_pkg::*;

    logic              refresh_req, refresh_ack;
    logic              bank_open, row_hit;
    logic              activate, precharge_all, read_issued;
    logic [BANK_W-1:0] req_bank;
    logic [ROW_W-1:0]  req_row;
    sdram_cmd_t        sdram_cmd;

    sdram_cmd_seq u_seq (
        .clk(clk), .rst(rst),
        .i_in_valid(i_in_valid), .i_rw(i_rw),
        .i_user_addr(i_user_addr), .i_data_in(i_data_in),
        .o_busy(o_busy),
        .i_refresh_req(refresh_req), .o_refresh_ack(refresh_ack),
        .i_bank_open(bank_open), .i_row_hit(row_hit),
        .o_req_bank(req_bank), .o_req_row(req_row),
        .o_activate(activate), .o_precharge_all(precharge_all),
        .o_read_issued(read_issued),
        .o_sdram_cle(o_sdram_cle), .o_sdram_cmd(sdram_cmd),
        .o_sdram_ba(o_sdram_ba), .o_sdram_a(o_sdram_a),
        .o_sdram_dqo(o_sdram_dqo), .o_sdram_dq_oe(o_sdram_dq_oe)
    );

    refresh_timer u_refresh (
        .clk(clk), .rst(rst),
        .i_refresh_ack(refresh_ack), .o_refresh_req(refresh_req)
    );

    open_row_table u_rows (
        .clk(clk), .rst(rst),
        .i_bank(req_bank), .i_row(req_row),
        .i_activate(activate), .i_precharge_all(precharge_all),
        .o_bank_open(bank_open), .o_row_hit(row_hit)
    );

    read_capture u_capture (
        .clk(clk), .rst(rst),
        .i_read_issued(read_issued), .i_sdram_dqi(i_sdram_dqi),
        .o_data_out(o_data_out), .o_out_valid(o_out_valid)
    );

    // command code order is cs, ras, cas, we
    assign {o_sdram_cs, o_sdram_ras, o_sdram_cas, o_sdram_we} = sdram_cmd;
    assign o_sdram_dqm = 1'b0;   // full words only

endmodule

/* bench/sdram_ctrl_sva.sv */
`timescale 1ns/1ps

module sdram_ctrl_sva (
    input logic clk,
    input logic rst,
    input logic i_in_valid,
    input logic o_busy,
    input logic o_out_valid,
    input logic o_sdram_cs,
    input logic o_sdram_ras,
    input logic o_sdram_cas,
    input logic o_sdram_we,
    input logic o_sdram_dq_oe
);
    import sdram_dev_pkg::*;

    logic [3:0] pin_cmd;

    assign pin_cmd = {o_sdram_cs, o_sdram_ras, o_sdram_cas, o_sdram_we};

    // data pins only driven together with a WRITE
    oe_with_write: assert property (@(posedge clk) disable iff (rst)
        o_sdram_dq_oe |-> pin_cmd == CMD_WRITE)
        else $error("dq_oe high without a WRITE command on the pins");

    valid_single_cycle: assert property (@(posedge clk) disable iff (rst)
        o_out_valid |=> !o_out_valid)
        else $error("o_out_valid held for two cycles");

    busy_after_accept: assert property (@(posedge clk) disable iff (rst)
        i_in_valid && !o_busy |=> o_busy)
        else $error("o_busy low in the cycle after an accepted request");

endmodule

/* bench/tb_sdram_ctrl.sv */
`timescale 1ns/1ps

module tb_sdram_ctrl;
    import sdram_dev_pkg::*;
    import sdram_user_pkg::*;

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   i_in_valid, i_rw;
    logic [USER_ADDR_W-1:0] i_user_addr;
    logic [DATA_W-1:0]      i_data_in, i_sdram_dqi, o_data_out, o_sdram_dqo;
    logic                   o_busy, o_out_valid, o_sdram_cle, o_sdram_dqm, o_sdram_dq_oe;
    logic                   o_sdram_cs, o_sdram_ras, o_sdram_cas, o_sdram_we;
    logic [BANK_W-1:0]      o_sdram_ba;
    logic [ROW_W-1:0]       o_sdram_a;
    sdram_cmd_t             pin_cmd;

    int errors = 0, checks = 0, timeouts = 0;
    int cycle = 0, read_cycle = 0, refreshes = 0;
    sdram_cmd_t last_cmd = CMD_NOP;     // last command other than NOP

    // commands seen since the current request went in
    logic              saw_act, saw_pre, acc_seen;
    logic [BANK_W-1:0] act_bank;
    logic [ROW_W-1:0]  act_row;
    logic [COL_W-1:0]  acc_col;
    sdram_cmd_t        acc_cmd;

    // memory device model, keyed by {bank, row, column}
    logic [DATA_W-1:0] dev_mem [logic [22:0]];
    logic [ROW_W-1:0]  dev_row [NUM_BANKS];
    logic [DATA_W-1:0] rd_pipe [CAS_LATENCY+1];

    // reference model, per user address and per bank
    logic [DATA_W-1:0]      ref_mem [logic [USER_ADDR_W-1:0]];
    logic                   ref_open [NUM_BANKS];
    logic [ROW_W-1:0]       ref_row [NUM_BANKS];
    logic [DATA_W-1:0]      exp_q [$];
    logic [USER_ADDR_W-1:0] written [$];

    sdram_ctrl_top dut (.*);

    bind sdram_ctrl_top sdram_ctrl_sva u_sva (
        .clk(clk), .rst(rst), .i_in_valid(i_in_valid), .o_busy(o_busy),
        .o_out_valid(o_out_valid), .o_sdram_dq_oe(o_sdram_dq_oe),
        .o_sdram_cs(o_sdram_cs), .o_sdram_ras(o_sdram_ras),
        .o_sdram_cas(o_sdram_cas), .o_sdram_we(o_sdram_we)
    );

    always #50 clk = ~clk;

    assign pin_cmd = sdram_cmd_t'({o_sdram_cs, o_sdram_ras, o_sdram_cas, o_sdram_we});

    // bank in 22:21, row in 20:8, column in 7:0
    function automatic logic [22:0] remap(input logic [USER_ADDR_W-1:0] addr);
        return {addr[12:11], addr[22:13], addr[10:8], addr[7:0]};
    endfunction

    task automatic check_data(input string name, input logic [DATA_W-1:0] got, want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("error at %0t: %s got %h expected %h", $time, name, got, want);
        end
    endtask

    task automatic check_cmd(input string name, input sdram_cmd_t got, want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("error at %0t: %s got %s expected %s", $time, name, got.name(), want.name());
        end
    endtask

    task automatic check_field(input string name, input logic [ROW_W-1:0] got, want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("error at %0t: %s got %h expected %h", $time, name, got, want);
        end
    endtask

    task automatic check_bit(input string name, input logic got, want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("error at %0t: %s got %b expected %b", $time, name, got, want);
        end
    endtask

    // device side, sampled once the pins have settled
    always @(posedge clk) begin
        #1;
        cycle++;
        for (int i = CAS_LATENCY; i > 0; i--)
            rd_pipe[i] = rd_pipe[i-1];
        rd_pipe[0] = '0;
        case (pin_cmd)
            CMD_ACTIVE: begin
                dev_row[o_sdram_ba] = o_sdram_a;
                if (!acc_seen) begin
                    saw_act  = 1'b1;
                    act_bank = o_sdram_ba;
                    act_row  = o_sdram_a;
                end
            end
            CMD_PRECHARGE: begin
                saw_pre = saw_pre | !acc_seen;  // later ones belong to a refresh
                check_bit("precharge a[10]", o_sdram_a[10], 1'b1);
            end
            CMD_WRITE, CMD_READ: begin
                acc_seen = 1'b1;
                acc_cmd  = pin_cmd;
                acc_col  = o_sdram_a[9:2];
                if (pin_cmd == CMD_WRITE) begin
                    dev_mem[{o_sdram_ba, dev_row[o_sdram_ba], o_sdram_a[9:2]}] = o_sdram_dqo;
                end else begin
                    rd_pipe[0] = dev_mem[{o_sdram_ba, dev_row[o_sdram_ba], o_sdram_a[9:2]}];
                    read_cycle = cycle;
                end
                check_bit("o_sdram_dq_oe", o_sdram_dq_oe, pin_cmd == CMD_WRITE);
                check_bit("o_sdram_dqm", o_sdram_dqm, 1'b0);
            end
            CMD_REFRESH: begin
                refreshes++;
                check_cmd("command before refresh", last_cmd, CMD_PRECHARGE);
                for (int b = 0; b < NUM_BANKS; b++)
                    ref_open[b] = 1'b0;   // all banks closed by the precharge
            end
            default: ;
        endcase
        if (pin_cmd != CMD_NOP)
            last_cmd = pin_cmd;
        i_sdram_dqi = rd_pipe[CAS_LATENCY];     // CAS_LATENCY cycles after READ
    end

    // each returned word against the reference, and its distance from READ
    always @(posedge clk) begin
        #2;
        if (o_out_valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("o_out_valid at %0t with no read outstanding", $time);
            end else begin
                check_data("o_data_out", o_data_out, exp_q.pop_front());
                if (cycle - read_cycle != CAS_LATENCY + 1) begin
                    errors++;
                    $display("error at %0t: read latency got %0d expected %0d",
                             $time, cycle - read_cycle, CAS_LATENCY + 1);
                end
            end
        end
    end

    task automatic wait_idle(input int limit);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            #1;
            n++;
        end while (o_busy && n < limit);
        if (o_busy) begin
            timeouts++;
            $display("timeout at %0t: o_busy stayed high", $time);
        end
    endtask

    task automatic wait_read(input int limit);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < limit) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (exp_q.size() != 0) begin
            timeouts++;
            $display("timeout at %0t: read data never came back", $time);
            exp_q.delete();
        end
    endtask

    // one request, then the row policy and fields it should have produced
    task automatic access(input logic rw, input logic [USER_ADDR_W-1:0] addr,
                          input logic [DATA_W-1:0] data);
        logic [22:0]       m;
        logic [BANK_W-1:0] b;
        logic [ROW_W-1:0]  r;
        logic              was_open, hit;
        m = remap(addr);
        b = m[22:21];
        r = m[20:8];
        wait_idle(50);
        was_open = ref_open[b];
        hit      = was_open && ref_row[b] == r;
        if (was_open && !hit) begin
            for (int i = 0; i < NUM_BANKS; i++)
                ref_open[i] = 1'b0;     // row miss closes everything
        end
        ref_open[b] = 1'b1;
        ref_row[b]  = r;
        saw_act     = 1'b0;
        saw_pre     = 1'b0;
        acc_seen    = 1'b0;
        acc_cmd     = CMD_NOP;
        i_in_valid  = 1'b1;
        i_rw        = rw;
        i_user_addr = addr;
        i_data_in   = data;
        if (rw) begin
            ref_mem[addr] = data;
            written.push_back(addr);
        end else begin
            exp_q.push_back(ref_mem[addr]);
        end
        @(posedge clk);
        #1;
        i_in_valid = 1'b0;
        if (rw)
            wait_idle(50);
        else
            wait_read(50);
        check_bit("precharge before access", saw_pre, was_open && !hit);
        check_bit("activate before access", saw_act, !hit);
        if (saw_act) begin
            check_field("activate bank", act_bank, b);
            check_field("activate row", act_row, r);
        end
        check_cmd("access command", acc_cmd, rw ? CMD_WRITE : CMD_READ);
        check_field("access column", acc_col, m[7:0]);
    endtask

    initial begin
        logic [USER_ADDR_W-1:0] a;
        int                     ref0;
        void'($urandom(32'hd7cb98fa));
        rst         = 1'b1;
        i_in_valid  = 1'b0;
        i_rw        = 1'b0;
        i_user_addr = '0;
        i_data_in   = '0;
        i_sdram_dqi = '0;
        saw_act     = 1'b0;
        saw_pre     = 1'b0;
        acc_seen    = 1'b1;
        for (int i = 0; i < NUM_BANKS; i++)
            ref_open[i] = 1'b0;
        for (int i = 0; i <= CAS_LATENCY; i++)
            rd_pipe[i] = '0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);
        #1;
        check_bit("o_out_valid", o_out_valid, 1'b0);
        check_bit("o_sdram_dq_oe", o_sdram_dq_oe, 1'b0);
        check_bit("o_busy", o_busy, 1'b1);
        check_cmd("command after reset", pin_cmd, CMD_NOP);
        wait_idle(20);
        check_bit("o_sdram_cle", o_sdram_cle, 1'b1);

        // closed bank, hit, miss in the same bank, then another bank
        a = 23'h2a5c3d;
        access(1'b1, a, 32'h1234_5678);
        access(1'b0, a, '0);
        access(1'b1, a ^ 23'h002000, 32'hcafe_0001);
        access(1'b0, a ^ 23'h002000, '0);
        access(1'b1, a ^ 23'h000800, 32'hcafe_0002);
        access(1'b0, a, '0);
        access(1'b0, a ^ 23'h000800, '0);

        // narrow address mask so rows and banks collide often
        repeat (40) begin
            if (written.size() == 0 || $urandom_range(1, 0) == 1)
                access(1'b1, 23'($urandom) & 23'h006b0f, $urandom);
            else
                access(1'b0, written[$urandom_range(written.size() - 1, 0)], '0);
        end

        ref0 = refreshes;
        repeat (3000) @(posedge clk);
        if (refreshes - ref0 < 3) begin
            errors++;
            $display("only %0d refresh commands in 3000 idle cycles", refreshes - ref0);
        end

        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

/* sdram_ctrl.f */
design/sdram_dev_pkg.sv
design/sdram_user_pkg.sv
design/refresh_timer.sv
design/open_row_table.sv
design/read_capture.sv
design/sdram_cmd_seq.sv
design/sdram_ctrl_top.sv
bench/sdram_ctrl_sva.sv
bench/tb_sdram_ctrl.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_sdram_ctrl -f sdram_ctrl.f \
    && ./obj_dir/Vtb_sdram_ctrl > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Simulation completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
